// ==== fc_pkg.sv ====
`default_nettype none

package fc_pkg;

    // Datapath widths
    typedef logic signed [15:0] data_t;
    typedef logic signed [31:0] acc_t;

    // APB widths
    typedef logic [15:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Region codes in paddr[15:12]
    localparam logic [3:0] REGION_CTRL   = 4'h0;
    localparam logic [3:0] REGION_INPUT  = 4'h1;
    localparam logic [3:0] REGION_BIAS   = 4'h2;
    localparam logic [3:0] REGION_RESULT = 4'h3;
    localparam logic [3:0] REGION_WEIGHT = 4'h8;

    // Offsets inside the CTRL region
    localparam logic [11:0] CTRL_OFFSET   = 12'h000;
    localparam logic [11:0] STATUS_OFFSET = 12'h004;

    // Bit positions in the control and status words
    localparam int CTRL_START_BIT  = 0;
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;

    // Sequencer states
    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        RUN,
        DRAIN,
        DONE
    } seq_state_t;

endpackage

`default_nettype wire

// ==== apb_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module apb_regs #(
    parameter int NUM_INPUTS  = 84,
    parameter int NUM_OUTPUTS = 10,
    localparam int IN_W       = $clog2(NUM_INPUTS),
    localparam int OUT_W      = $clog2(NUM_OUTPUTS)
) (
    input  logic                           clk,
    input  logic                           reset,
    input  fc_pkg::apb_addr_t              paddr,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  fc_pkg::apb_data_t              pwdata,
    output fc_pkg::apb_data_t              prdata,
    output logic                           pready,
    input  logic                           busy,
    input  logic                           done,
    input  fc_pkg::acc_t [NUM_OUTPUTS-1:0] results,
    output logic                           in_we,
    output logic [IN_W-1:0]                in_idx,
    output fc_pkg::data_t                  in_data,
    output logic [NUM_OUTPUTS-1:0]         w_we,
    output logic [IN_W-1:0]                w_addr,
    output fc_pkg::data_t                  w_data,
    output logic                           b_we,
    output logic [OUT_W-1:0]               b_idx,
    output fc_pkg::acc_t                   b_data,
    output logic                           start
);

    logic [3:0]        region;
    logic [11:0]       offset;
    logic [9:0]        elem_idx;
    logic [6:0]        w_in_idx;
    logic [5:0]        w_neuron;
    logic              is_weight;
    logic              access;
    logic              wr_ok;
    logic [9:0]        wr_idx;
    fc_pkg::apb_data_t wr_data;

    assign region   = paddr[15:12];
    assign offset   = paddr[11:0];
    assign elem_idx = paddr[11:2];
    assign w_in_idx = paddr[8:2];

    // Weight region fills the upper half, so the neuron field runs up to bit 14
    assign is_weight = (region & fc_pkg::REGION_WEIGHT) == fc_pkg::REGION_WEIGHT;
    assign w_neuron  = paddr[14:9];

    assign access = psel & penable;
    assign wr_ok  = access & pwrite & ~busy;

    // No wait states
    assign pready = 1'b1;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            in_we <= 1'b0;
            w_we  <= '0;
            b_we  <= 1'b0;
            start <= 1'b0;
        end
        else
        begin
            in_we <= wr_ok && !is_weight && region == fc_pkg::REGION_INPUT
                     && elem_idx < NUM_INPUTS;
            b_we  <= wr_ok && !is_weight && region == fc_pkg::REGION_BIAS
                     && elem_idx < NUM_OUTPUTS;
            start <= wr_ok && !is_weight && region == fc_pkg::REGION_CTRL
                     && offset == fc_pkg::CTRL_OFFSET && pwdata[fc_pkg::CTRL_START_BIT];
            w_we  <= '0;
            if (wr_ok && is_weight && w_in_idx < NUM_INPUTS && w_neuron < NUM_OUTPUTS)
                w_we[w_neuron[OUT_W-1:0]] <= 1'b1;
        end
    end

    // Index and data shared by all storage strobes
    always_ff @(posedge clk)
    begin
        if (wr_ok)
        begin
            wr_idx  <= elem_idx;
            wr_data <= pwdata;
        end
    end

    // Input index of a weight sits in the same bits as an element index
    assign in_idx  = wr_idx[IN_W-1:0];
    assign w_addr  = wr_idx[IN_W-1:0];
    assign b_idx   = wr_idx[OUT_W-1:0];
    assign in_data = wr_data[15:0];
    assign w_data  = wr_data[15:0];
    assign b_data  = wr_data;

    always_comb
    begin
        prdata = '0;
        if (access && !pwrite)
        begin
            if (region == fc_pkg::REGION_CTRL && offset == fc_pkg::STATUS_OFFSET)
            begin
                prdata[fc_pkg::STATUS_BUSY_BIT] = busy;
                prdata[fc_pkg::STATUS_DONE_BIT] = done;
            end
            else if (region == fc_pkg::REGION_RESULT && elem_idx < NUM_OUTPUTS)
                prdata = results[elem_idx[OUT_W-1:0]];
        end
    end

endmodule

`default_nettype wire

// ==== activation_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module activation_buffer #(
    parameter int NUM_INPUTS = 84,
    localparam int IN_W      = $clog2(NUM_INPUTS)
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            in_we,
    input  logic [IN_W-1:0] in_idx,
    input  fc_pkg::data_t   in_data,
    input  logic [IN_W-1:0] rd_idx,
    input  logic            rd_en,
    output fc_pkg::data_t   act
);

    fc_pkg::data_t mem [NUM_INPUTS];
    fc_pkg::data_t sel;
    fc_pkg::data_t relu;

    assign sel = mem[rd_idx];

    // ReLU, negative activations become zero
    assign relu = (sel < 0) ? '0 : sel;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < NUM_INPUTS; i++)
                mem[i] <= '0;
            act <= '0;
        end
        else
        begin
            if (in_we)
                mem[in_idx] <= in_data;
            // Operand lines up with the weight read
            if (rd_en)
                act <= relu;
        end
    end

endmodule

`default_nettype wire

// ==== weight_bank.sv ====
`timescale 1ns/100ps
`default_nettype none

module weight_bank #(
    parameter int NUM_INPUTS  = 84,
    parameter int NUM_OUTPUTS = 10,
    localparam int IN_W       = $clog2(NUM_INPUTS)
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [NUM_OUTPUTS-1:0]          w_we,
    input  logic [IN_W-1:0]                 w_addr,
    input  fc_pkg::data_t                   w_data,
    input  logic [IN_W-1:0]                 rd_idx,
    input  logic                            rd_en,
    output fc_pkg::data_t [NUM_OUTPUTS-1:0] weights
);

    logic [IN_W-1:0] addr;

    // Single port, so the pass owns the address while reading
    assign addr = rd_en ? rd_idx : w_addr;

    for (genvar j = 0; j < NUM_OUTPUTS; j++)
    begin : g_lane
        fc_pkg::data_t mem [NUM_INPUTS];
        fc_pkg::data_t rd_q;

        always_ff @(posedge clk or posedge reset)
        begin
            if (reset)
            begin
                for (int i = 0; i < NUM_INPUTS; i++)
                    mem[i] <= '0;
                rd_q <= '0;
            end
            else
            begin
                if (w_we[j])
                    mem[addr] <= w_data;
                if (rd_en)
                    rd_q <= mem[addr];
            end
        end

        assign weights[j] = rd_q;
    end

endmodule

`default_nettype wire

// ==== mac_array.sv ====
`timescale 1ns/100ps
`default_nettype none

module mac_array #(
    parameter int NUM_OUTPUTS = 10,
    localparam int OUT_W      = $clog2(NUM_OUTPUTS)
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            b_we,
    input  logic [OUT_W-1:0]                b_idx,
    input  fc_pkg::acc_t                    b_data,
    input  logic                            clear_acc,
    input  logic                            acc_en,
    input  logic                            latch,
    input  fc_pkg::data_t                   act,
    input  fc_pkg::data_t [NUM_OUTPUTS-1:0] weights,
    output fc_pkg::acc_t  [NUM_OUTPUTS-1:0] results
);

    fc_pkg::acc_t bias [NUM_OUTPUTS];
    fc_pkg::acc_t acc  [NUM_OUTPUTS];
    fc_pkg::acc_t prod [NUM_OUTPUTS];

    // 16x16 signed product fits 32 bits, the sum wraps
    always_comb
    begin
        for (int j = 0; j < NUM_OUTPUTS; j++)
            prod[j] = fc_pkg::acc_t'(act) * fc_pkg::acc_t'(weights[j]);
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int j = 0; j < NUM_OUTPUTS; j++)
                bias[j] <= '0;
        end
        else if (b_we)
        begin
            for (int j = 0; j < NUM_OUTPUTS; j++)
            begin
                if (b_idx == OUT_W'(j))
                    bias[j] <= b_data;
            end
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int j = 0; j < NUM_OUTPUTS; j++)
            begin
                acc[j]     <= '0;
                results[j] <= '0;
            end
        end
        else
        begin
            for (int j = 0; j < NUM_OUTPUTS; j++)
            begin
                if (clear_acc)
                    acc[j] <= bias[j];
                else if (acc_en)
                    acc[j] <= acc[j] + prod[j];
                // Results only move at the end of a pass
                if (latch)
                    results[j] <= acc[j];
            end
        end
    end

endmodule

`default_nettype wire

// ==== fc_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module fc_sequencer #(
    parameter int NUM_INPUTS = 84,
    localparam int IN_W      = $clog2(NUM_INPUTS)
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    output logic [IN_W-1:0] rd_idx,
    output logic            rd_en,
    output logic            clear_acc,
    output logic            acc_en,
    output logic            latch,
    output logic            busy,
    output logic            done
);

    localparam logic [IN_W-1:0] LAST_IDX = IN_W'(NUM_INPUTS - 1);

    fc_pkg::seq_state_t state;
    logic [IN_W-1:0]    idx;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state  <= fc_pkg::IDLE;
            idx    <= '0;
            acc_en <= 1'b0;
            latch  <= 1'b0;
        end
        else
        begin
            // Memory and operand registers add one cycle of latency
            acc_en <= rd_en;
            // Last accumulate lands at the end of DRAIN
            latch  <= (state == fc_pkg::DRAIN);

            case (state)
                fc_pkg::IDLE,
                fc_pkg::DONE:
                begin
                    if (start)
                        state <= fc_pkg::CLEAR;
                end
                fc_pkg::CLEAR:
                begin
                    idx   <= '0;
                    state <= fc_pkg::RUN;
                end
                fc_pkg::RUN:
                begin
                    idx <= idx + 1'b1;
                    if (idx == LAST_IDX)
                        state <= fc_pkg::DRAIN;
                end
                fc_pkg::DRAIN:
                    state <= fc_pkg::DONE;
                default:
                    state <= fc_pkg::IDLE;
            endcase
        end
    end

    assign rd_idx    = idx;
    assign rd_en     = (state == fc_pkg::RUN);
    assign clear_acc = (state == fc_pkg::CLEAR);
    assign busy      = (state == fc_pkg::CLEAR) || (state == fc_pkg::RUN)
                       || (state == fc_pkg::DRAIN);
    // Stays up until the next start
    assign done      = (state == fc_pkg::DONE);

endmodule

`default_nettype wire

// ==== fc_layer_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module fc_layer_top #(
    parameter int NUM_INPUTS  = 84,
    parameter int NUM_OUTPUTS = 10,
    localparam int IN_W       = $clog2(NUM_INPUTS),
    localparam int OUT_W      = $clog2(NUM_OUTPUTS)
) (
    input  logic              clk,
    input  logic              reset,
    input  fc_pkg::apb_addr_t paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  fc_pkg::apb_data_t pwdata,
    output fc_pkg::apb_data_t prdata,
    output logic              pready,
    output logic              done
);

    // Host writes into storage
    logic                   in_we;
    logic [IN_W-1:0]        in_idx;
    fc_pkg::data_t          in_data;
    logic [NUM_OUTPUTS-1:0] w_we;
    logic [IN_W-1:0]        w_addr;
    fc_pkg::data_t          w_data;
    logic                   b_we;
    logic [OUT_W-1:0]       b_idx;
    fc_pkg::acc_t           b_data;
    logic                   start;

    // Read pipeline
    logic [IN_W-1:0]                 rd_idx;
    logic                            rd_en;
    logic                            clear_acc;
    logic                            acc_en;
    logic                            latch;
    logic                            busy;
    fc_pkg::data_t                   act;
    fc_pkg::data_t [NUM_OUTPUTS-1:0] weights;
    fc_pkg::acc_t  [NUM_OUTPUTS-1:0] results;

    apb_regs #(
        .NUM_INPUTS  (NUM_INPUTS),
        .NUM_OUTPUTS (NUM_OUTPUTS)
    ) i_apb_regs (
        .clk     (clk),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .busy    (busy),
        .done    (done),
        .results (results),
        .in_we   (in_we),
        .in_idx  (in_idx),
        .in_data (in_data),
        .w_we    (w_we),
        .w_addr  (w_addr),
        .w_data  (w_data),
        .b_we    (b_we),
        .b_idx   (b_idx),
        .b_data  (b_data),
        .start   (start)
    );

    fc_sequencer #(
        .NUM_INPUTS (NUM_INPUTS)
    ) i_sequencer (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .rd_idx    (rd_idx),
        .rd_en     (rd_en),
        .clear_acc (clear_acc),
        .acc_en    (acc_en),
        .latch     (latch),
        .busy      (busy),
        .done      (done)
    );

    activation_buffer #(
        .NUM_INPUTS (NUM_INPUTS)
    ) i_act_buf (
        .clk     (clk),
        .reset   (reset),
        .in_we   (in_we),
        .in_idx  (in_idx),
        .in_data (in_data),
        .rd_idx  (rd_idx),
        .rd_en   (rd_en),
        .act     (act)
    );

    weight_bank #(
        .NUM_INPUTS  (NUM_INPUTS),
        .NUM_OUTPUTS (NUM_OUTPUTS)
    ) i_weight_bank (
        .clk     (clk),
        .reset   (reset),
        .w_we    (w_we),
        .w_addr  (w_addr),
        .w_data  (w_data),
        .rd_idx  (rd_idx),
        .rd_en   (rd_en),
        .weights (weights)
    );

    mac_array #(
        .NUM_OUTPUTS (NUM_OUTPUTS)
    ) i_mac_array (
        .clk       (clk),
        .reset     (reset),
        .b_we      (b_we),
        .b_idx     (b_idx),
        .b_data    (b_data),
        .clear_acc (clear_acc),
        .acc_en    (acc_en),
        .latch     (latch),
        .act       (act),
        .weights   (weights),
        .results   (results)
    );

endmodule

`default_nettype wire

// ==== fc_layer_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module fc_layer_tb;

    localparam int N_IN  = 84;
    localparam int N_OUT = 10;
    // Six passes of about 1000 two-cycle transfers plus the pass, half again as margin
    localparam int MAX_CYCLES = (6 * (1000 * 2 + N_IN + 3) * 3) / 2;

    logic              clk;
    logic              reset;
    fc_pkg::apb_addr_t paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    fc_pkg::apb_data_t pwdata;
    fc_pkg::apb_data_t prdata;
    logic              pready;
    logic              done;

    logic [31:0]   rng_state;
    int            error_count;
    int            check_count;
    int            cycle_count = 0;
    fc_pkg::data_t model_x [N_IN];
    fc_pkg::data_t model_w [N_OUT][N_IN];
    fc_pkg::acc_t  model_b [N_OUT];
    fc_pkg::acc_t  expected [N_OUT];

    fc_layer_top i_dut (
        .clk     (clk),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .done    (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic fc_pkg::apb_addr_t elem_addr(input logic [3:0] region, input int idx);
        return {region, 10'(idx), 2'b00};
    endfunction

    // Neuron field starts at bit 9 and runs on into the upper half
    function automatic fc_pkg::apb_addr_t weight_addr(input int neuron, input int idx);
        return {1'b1, 6'(neuron), 7'(idx), 2'b00};
    endfunction

    // Setup cycle, then access cycle, then back to idle
    task automatic apb_write(input fc_pkg::apb_addr_t addr, input fc_pkg::apb_data_t data);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input fc_pkg::apb_addr_t addr, output fc_pkg::apb_data_t data);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        // Mid access cycle
        #4;
        data = prdata;
        check_word("pready", {31'b0, pready}, 32'h1);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_word(input string what, input fc_pkg::apb_data_t got,
                              input fc_pkg::apb_data_t exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("Error at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic check_result(input int idx, input fc_pkg::acc_t got, input fc_pkg::acc_t exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("Error at %0t: result %0d is %0d, expected %0d", $time, idx, got, exp);
        end
    endtask

    task automatic load_random_weights();
        fc_pkg::data_t w;
        for (int j = 0; j < N_OUT; j++)
        begin
            for (int i = 0; i < N_IN; i++)
            begin
                w = fc_pkg::data_t'(xorshift32());
                model_w[j][i] = w;
                apb_write(weight_addr(j, i), fc_pkg::apb_data_t'(w));
            end
        end
    endtask

    task automatic load_random_biases();
        fc_pkg::acc_t b;
        for (int j = 0; j < N_OUT; j++)
        begin
            b = fc_pkg::acc_t'(xorshift32());
            model_b[j] = b;
            apb_write(elem_addr(fc_pkg::REGION_BIAS, j), fc_pkg::apb_data_t'(b));
        end
    endtask

    task automatic load_random_inputs(input bit negative);
        logic [31:0]   r;
        fc_pkg::data_t x;
        for (int i = 0; i < N_IN; i++)
        begin
            r = xorshift32();
            x = negative ? fc_pkg::data_t'({1'b1, r[14:0]}) : fc_pkg::data_t'(r[15:0]);
            model_x[i] = x;
            apb_write(elem_addr(fc_pkg::REGION_INPUT, i), fc_pkg::apb_data_t'(x));
        end
    endtask

    // bias plus sum of max(x, 0) * w, kept wide then wrapped to 32 bits
    task automatic compute_model();
        longint sum;
        for (int j = 0; j < N_OUT; j++)
        begin
            sum = longint'(model_b[j]);
            for (int i = 0; i < N_IN; i++)
            begin
                if (model_x[i] > 0)
                    sum = sum + longint'(model_x[i]) * longint'(model_w[j][i]);
            end
            expected[j] = fc_pkg::acc_t'(sum);
        end
    endtask

    task automatic wait_done();
        fc_pkg::apb_data_t status;
        do
            apb_read(elem_addr(fc_pkg::REGION_CTRL, 1), status);
        while (!status[fc_pkg::STATUS_DONE_BIT]);
        check_word("status at done", status, 32'h2);
        check_word("done port", {31'b0, done}, 32'h1);
    endtask

    task automatic run_pass();
        apb_write(elem_addr(fc_pkg::REGION_CTRL, 0), 32'h1);
        wait_done();
    endtask

    task automatic check_results();
        fc_pkg::apb_data_t rd;
        for (int j = 0; j < N_OUT; j++)
        begin
            apb_read(elem_addr(fc_pkg::REGION_RESULT, j), rd);
            check_result(j, fc_pkg::acc_t'(rd), expected[j]);
        end
    endtask

    task automatic expect_zero(input string what, input fc_pkg::apb_addr_t addr);
        fc_pkg::apb_data_t rd;
        apb_read(addr, rd);
        check_word(what, rd, 32'h0);
    endtask

    initial
    begin : stimulus
        fc_pkg::apb_data_t rd;
        reset       = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        rng_state   = 32'd39688;
        error_count = 0;
        check_count = 0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        @(posedge clk);
        #1;

        // Everything clear after reset
        apb_read(elem_addr(fc_pkg::REGION_CTRL, 1), rd);
        check_word("status after reset", rd, 32'h0);
        for (int j = 0; j < N_OUT; j++)
            expected[j] = '0;
        check_results();

        // Full random pass
        load_random_weights();
        load_random_biases();
        load_random_inputs(1'b0);
        compute_model();
        run_pass();
        check_results();

        // ReLU zeroes every term
        load_random_inputs(1'b1);
        for (int j = 0; j < N_OUT; j++)
            expected[j] = model_b[j];
        run_pass();
        check_results();

        // Weights and biases retained
        load_random_inputs(1'b0);
        compute_model();
        run_pass();
        check_results();

        // Writes while busy, model left untouched
        load_random_inputs(1'b0);
        apb_write(elem_addr(fc_pkg::REGION_CTRL, 0), 32'h1);
        apb_read(elem_addr(fc_pkg::REGION_CTRL, 1), rd);
        check_word("status during pass", rd, 32'h1);
        check_word("done port during pass", {31'b0, done}, 32'h0);
        apb_read(elem_addr(fc_pkg::REGION_RESULT, 0), rd);
        check_result(0, fc_pkg::acc_t'(rd), expected[0]);
        for (int i = 0; i < 4; i++)
            apb_write(elem_addr(fc_pkg::REGION_INPUT, i), xorshift32());
        apb_write(elem_addr(fc_pkg::REGION_BIAS, 0), xorshift32());
        apb_write(elem_addr(fc_pkg::REGION_BIAS, 1), xorshift32());
        apb_write(elem_addr(fc_pkg::REGION_CTRL, 0), 32'h1);
        wait_done();
        compute_model();
        check_results();

        // A fresh pass still sees the values loaded before the busy writes
        run_pass();
        check_results();

        // Write-only and unmapped space
        expect_zero("weight read", weight_addr(3, 7));
        expect_zero("input read", elem_addr(fc_pkg::REGION_INPUT, 5));
        expect_zero("bias read", elem_addr(fc_pkg::REGION_BIAS, 2));
        expect_zero("control read", elem_addr(fc_pkg::REGION_CTRL, 0));
        expect_zero("unmapped control offset", elem_addr(fc_pkg::REGION_CTRL, 2));
        expect_zero("unmapped region", elem_addr(4'h4, 0));
        expect_zero("result past last neuron", elem_addr(fc_pkg::REGION_RESULT, N_OUT));
        apb_write(elem_addr(fc_pkg::REGION_RESULT, 0), 32'hdead_beef);
        apb_write(elem_addr(fc_pkg::REGION_RESULT, 5), 32'h1234_5678);
        check_results();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
fc_pkg.sv
apb_regs.sv
activation_buffer.sv
weight_bank.sv
mac_array.sv
fc_sequencer.sv
fc_layer_top.sv
fc_layer_tb.sv
